//--- build.f
design/idct_pkg.sv
design/block_ram_if.sv
design/block_dpram.sv
design/fetch_block.sv
design/compute_t.sv
design/compute_s.sv
design/write_block.sv
design/idct_top.sv
tb/tb_idct_assert.sv
tb/tb_idct.sv

//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = tb_idct
FILELIST = build.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/tb_idct.sv
`timescale 1ns/1ps

module tb_idct;
    import idct_pkg::*;

    localparam int COEF_WORDS = BLOCK_ROWS * 8 * IMG_WIDTH;
    localparam int PIXEL_WORDS = BLOCK_ROWS * 8 * IMG_WIDTH / 2;
    localparam int DONE_TIMEOUT = 40000;
    localparam int IDLE_TIMEOUT = 100;
    localparam int FRAME_ZERO = 0;
    localparam int FRAME_RANDOM = 1;
    localparam int FRAME_DC = 2;

    logic Clock_50 = 1'b0;
    logic Resetn = 1'b0;
    logic start = 1'b0;
    logic done;
    sram_addr_t sram_address;
    sram_data_t sram_write_data;
    logic sram_we_n;
    sram_data_t sram_read_data;

    // Coefficient region as loaded, pixel region as written by the DUT
    sram_data_t coef_words [COEF_WORDS];
    sram_data_t pixel_words [PIXEL_WORDS];
    int written_frame [PIXEL_WORDS];
    sram_data_t expected [PIXEL_WORDS];
    sram_data_t read_pipe [SRAM_READ_LATENCY];

    logic [15:0] lfsr_state;
    logic timed_out;
    int frame_id;
    int done_count = 0;
    int value_errors;
    int other_errors;

    always #50 Clock_50 = ~Clock_50;

    idct_top dut (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .start(start),
        .done(done),
        .sram_address(sram_address),
        .sram_write_data(sram_write_data),
        .sram_we_n(sram_we_n),
        .sram_read_data(sram_read_data)
    );

    // Request and ack bits run fetch, compute T, compute S, write from bit 0
    // Write strobe covers the bus and the writer's own strobe
    bind idct_top tb_idct_assert handshake_checks (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .req({ws_req, cs_req, ct_req, fetch_req}),
        .ack({ws_ack, cs_ack, ct_ack, fetch_ack}),
        .done(done),
        .sram_we_n(sram_we_n & ws_we_n),
        .seq_state(seq_state)
    );

    assign sram_read_data = Resetn ? read_pipe[SRAM_READ_LATENCY-1] : '0;

    // SRAM model
    always @(posedge Clock_50) begin
        int offset;
        offset = int'(sram_address) - int'(PIXEL_BASE);
        if (int'(sram_address) < COEF_WORDS) begin
            read_pipe[0] <= coef_words[int'(sram_address)];
        end else if (offset >= 0 && offset < PIXEL_WORDS) begin
            read_pipe[0] <= pixel_words[offset];
        end else begin
            read_pipe[0] <= '0;
        end
        for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
            read_pipe[i] <= read_pipe[i-1];
        end
        if (Resetn && !sram_we_n) begin
            assert (offset >= 0 && offset < PIXEL_WORDS) else begin
                if (int'(sram_address) < COEF_WORDS) begin
                    $display("Write into the coefficient region at address 0x%h", sram_address);
                end else begin
                    $display("Write outside the pixel region at address 0x%h", sram_address);
                end
                other_errors++;
            end
            if (offset >= 0 && offset < PIXEL_WORDS) begin
                pixel_words[offset] <= sram_write_data;
                written_frame[offset] <= frame_id;
            end
        end
    end

    always @(posedge Clock_50) begin
        if (Resetn && done) begin
            done_count++;
        end
    end

    // Taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
    endfunction

    task automatic draw_bits(input int width, output int value);
        value = 0;
        for (int i = 0; i < width; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    task automatic fill_frame(input int kind);
        int value;
        logic dc_term;
        for (int r = 0; r < BLOCK_ROWS * 8; r++) begin
            for (int c = 0; c < IMG_WIDTH; c++) begin
                dc_term = (r % 8 == 0) && (c % 8 == 0);
                value = 0;
                if (kind == FRAME_RANDOM) begin
                    draw_bits(9, value);
                    value = value - 256;
                    // DC offset centers the pixels near mid grey
                    if (dc_term) value = value + 1024;
                end else if (kind == FRAME_DC) begin
                    draw_bits(6, value);
                    value = value - 32;
                    if (dc_term) value = ((r / 8 + c / 8) % 2 == 0) ? 8000 : -8000;
                end
                coef_words[r * IMG_WIDTH + c] = sram_data_t'(value);
            end
        end
    endtask

    // Reference IDCT, T = S' * C then S = C^T * T with clip
    task automatic compute_expected();
        int sp [8][8];
        int t [8][8];
        int pix [8][8];
        int sum;
        int word_idx;
        for (int br = 0; br < BLOCK_ROWS; br++) begin
            for (int bc = 0; bc < BLOCK_COLS; bc++) begin
                for (int r = 0; r < 8; r++) begin
                    for (int c = 0; c < 8; c++) begin
                        sp[r][c] = int'(coef_t'(coef_words[(br * 8 + r) * IMG_WIDTH + bc * 8 + c]));
                    end
                end
                for (int r = 0; r < 8; r++) begin
                    for (int c = 0; c < 8; c++) begin
                        sum = 0;
                        for (int k = 0; k < 8; k++) sum += sp[r][k] * IDCT_COEF[k][c];
                        t[r][c] = sum >>> T_SHIFT;
                    end
                end
                for (int r = 0; r < 8; r++) begin
                    for (int c = 0; c < 8; c++) begin
                        sum = 0;
                        for (int k = 0; k < 8; k++) sum += IDCT_COEF[k][r] * t[k][c];
                        sum = sum >>> S_SHIFT;
                        pix[r][c] = (sum < 0) ? 0 : ((sum > 255) ? 255 : sum);
                    end
                end
                for (int r = 0; r < 8; r++) begin
                    for (int c = 0; c < 8; c += 2) begin
                        word_idx = (br * 8 + r) * (IMG_WIDTH / 2) + bc * 4 + c / 2;
                        expected[word_idx] = sram_data_t'((pix[r][c] << 8) | pix[r][c + 1]);
                    end
                end
            end
        end
    endtask

    task automatic wait_for_done();
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clock_50);
            cycles++;
        end while (!done && cycles < DONE_TIMEOUT);
        if (!done) begin
            $display("Timed out after %0d cycles waiting for done", DONE_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_idle();
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clock_50);
            cycles++;
        end while (dut.seq_state != S_IDLE && cycles < IDLE_TIMEOUT);
        if (dut.seq_state != S_IDLE) begin
            $display("Timed out waiting for the sequencer to return to idle");
            timed_out = 1'b1;
        end
    endtask

    task automatic check_frame();
        sram_addr_t addr;
        for (int i = 0; i < PIXEL_WORDS; i++) begin
            addr = sram_addr_t'(int'(PIXEL_BASE) + i);
            assert (written_frame[i] == frame_id) else begin
                $display("Pixel word at address 0x%h was not written in frame %0d", addr, frame_id);
                other_errors++;
            end
            assert (pixel_words[i] == expected[i]) else begin
                $display("Error: sram_write_data at 0x%h expected 0x%h got 0x%h",
                    addr, expected[i], pixel_words[i]);
                value_errors++;
            end
        end
        assert (done_count == frame_id) else begin
            $display("done pulsed %0d times over %0d starts", done_count, frame_id);
            other_errors++;
        end
    endtask

    task automatic run_frame(input int kind);
        if (!timed_out) begin
            fill_frame(kind);
            compute_expected();
            frame_id++;
            wait_for_idle();
            @(posedge Clock_50);
            start <= 1'b1;
            @(posedge Clock_50);
            start <= 1'b0;
            wait_for_done();
            if (!timed_out) wait_for_idle();
            if (!timed_out) check_frame();
        end
    endtask

    initial begin
        lfsr_state = 16'd49;
        frame_id = 0;
        value_errors = 0;
        other_errors = 0;
        timed_out = 1'b0;
        repeat (16) @(posedge Clock_50);
        Resetn <= 1'b1;
        @(negedge Clock_50);
        assert (!done && sram_we_n) else begin
            $display("done or a write strobe is active right after reset");
            other_errors++;
        end

        run_frame(FRAME_ZERO);
        run_frame(FRAME_RANDOM);
        run_frame(FRAME_DC);
        // Restart after done with a fresh frame
        run_frame(FRAME_RANDOM);

        repeat (10) @(negedge Clock_50);
        assert (done_count == frame_id) else begin
            $display("done pulsed again with no start");
            other_errors++;
        end

        $display("Checks finished with %0d value errors, %0d other errors, %0d assertion failures",
            value_errors, other_errors, dut.handshake_checks.failures);
        if (value_errors == 0 && other_errors == 0 && !timed_out
                && dut.handshake_checks.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- tb/tb_idct_assert.sv
`timescale 1ns/1ps

module tb_idct_assert (
    input logic Clock_50,
    input logic Resetn,
    input logic [3:0] req,
    input logic [3:0] ack,
    input logic done,
    input logic sram_we_n,
    input idct_pkg::seq_state_t seq_state
);
    import idct_pkg::*;

    int failures = 0;

    // One bit per unit, all four checked together
    ack_needs_req: assert property (@(posedge Clock_50) disable iff (!Resetn)
        (ack & ~$past(ack) & ~req) == 4'b0000)
    else begin
        failures++;
        $error("An ack rose while its req was low");
    end

    req_held: assert property (@(posedge Clock_50) disable iff (!Resetn)
        ($past(req) & ~$past(ack) & ~req) == 4'b0000)
    else begin
        failures++;
        $error("A req dropped before its ack");
    end

    done_single: assert property (@(posedge Clock_50) disable iff (!Resetn)
        done |=> !done)
    else begin
        failures++;
        $error("done stayed high for more than one cycle");
    end

    no_write_in_fetch: assert property (@(posedge Clock_50) disable iff (!Resetn)
        (seq_state == S_LEADIN_FETCH || seq_state == S_COMMON_CS_FETCH) |-> sram_we_n)
    else begin
        failures++;
        $error("SRAM write strobe low during a fetch phase");
    end

endmodule

//--- design/idct_top.sv
`timescale 1ns/1ps

module idct_top (
    input logic Clock_50,
    input logic Resetn,
    input logic start,
    output logic done,
    output idct_pkg::sram_addr_t sram_address,
    output idct_pkg::sram_data_t sram_write_data,
    output logic sram_we_n,
    input idct_pkg::sram_data_t sram_read_data
);
    import idct_pkg::*;

    seq_state_t seq_state;

    logic fetch_req, fetch_ack, fetch_got;
    logic ct_req, ct_ack, ct_got;
    logic cs_req, cs_ack, cs_got;
    logic ws_req, ws_ack, ws_got;

    // Compute side block and the lagging write side block
    blk_idx_t blk_row, blk_col;
    blk_idx_t wr_row, wr_col;
    logic last_col, last_blk, wr_last_col;

    sram_addr_t fetch_address, ws_address;
    sram_data_t ws_write_data;
    logic fetch_we_n, ws_we_n;

    block_ram_if sprime_if ();
    block_ram_if t_if ();
    block_ram_if s_if ();

    block_dpram sprime_ram (.Clock_50(Clock_50), .ram(sprime_if.mem));
    block_dpram t_ram (.Clock_50(Clock_50), .ram(t_if.mem));
    block_dpram s_ram (.Clock_50(Clock_50), .ram(s_if.mem));

    fetch_block fetch_unit (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .req(fetch_req),
        .ack(fetch_ack),
        .block_row(blk_row),
        .block_col(blk_col),
        .sram_address(fetch_address),
        .sram_we_n(fetch_we_n),
        .sram_read_data(sram_read_data),
        .buf_wr(sprime_if.writer)
    );

    compute_t ct_unit (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .req(ct_req),
        .ack(ct_ack),
        .sp_rd(sprime_if.reader),
        .t_wr(t_if.writer)
    );

    compute_s cs_unit (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .req(cs_req),
        .ack(cs_ack),
        .t_rd(t_if.reader),
        .s_wr(s_if.writer)
    );

    write_block ws_unit (
        .Clock_50(Clock_50),
        .Resetn(Resetn),
        .req(ws_req),
        .ack(ws_ack),
        .block_row(wr_row),
        .block_col(wr_col),
        .sram_address(ws_address),
        .sram_write_data(ws_write_data),
        .sram_we_n(ws_we_n),
        .s_rd(s_if.reader)
    );

    assign last_col = (blk_col == blk_idx_t'(BLOCK_COLS - 1));
    assign last_blk = last_col && (blk_row == blk_idx_t'(BLOCK_ROWS - 1));
    assign wr_last_col = (wr_col == blk_idx_t'(BLOCK_COLS - 1));

    always_ff @(posedge Clock_50 or negedge Resetn) begin
        if (!Resetn) begin
            seq_state <= S_IDLE;
            done <= 1'b0;
            fetch_req <= 1'b0;
            ct_req <= 1'b0;
            cs_req <= 1'b0;
            ws_req <= 1'b0;
            fetch_got <= 1'b0;
            ct_got <= 1'b0;
            cs_got <= 1'b0;
            ws_got <= 1'b0;
            blk_row <= '0;
            blk_col <= '0;
            wr_row <= '0;
            wr_col <= '0;
        end else begin
            done <= 1'b0;
            // Drop req on ack and remember the unit has finished
            if (fetch_req && fetch_ack) begin
                fetch_req <= 1'b0;
                fetch_got <= 1'b1;
            end
            if (ct_req && ct_ack) begin
                ct_req <= 1'b0;
                ct_got <= 1'b1;
            end
            if (cs_req && cs_ack) begin
                cs_req <= 1'b0;
                cs_got <= 1'b1;
            end
            if (ws_req && ws_ack) begin
                ws_req <= 1'b0;
                ws_got <= 1'b1;
            end

            case (seq_state)
                S_IDLE: begin
                    if (start) begin
                        blk_row <= '0;
                        blk_col <= '0;
                        wr_row <= '0;
                        wr_col <= '0;
                        fetch_req <= 1'b1;
                        seq_state <= S_LEADIN_FETCH;
                    end
                end
                S_LEADIN_FETCH: begin
                    if (fetch_got && !fetch_ack) begin
                        fetch_got <= 1'b0;
                        ct_req <= 1'b1;
                        seq_state <= S_LEADIN_CT;
                    end
                end
                S_LEADIN_CT, S_COMMON_WS_CT: begin
                    if (ct_got && !ct_ack && (seq_state == S_LEADIN_CT || (ws_got && !ws_ack))) begin
                        ct_got <= 1'b0;
                        ws_got <= 1'b0;
                        if (seq_state == S_COMMON_WS_CT) begin
                            wr_col <= wr_last_col ? '0 : wr_col + 5'd1;
                            wr_row <= wr_last_col ? wr_row + 5'd1 : wr_row;
                        end
                        cs_req <= 1'b1;
                        if (last_blk) begin
                            seq_state <= S_LEADOUT_CS;
                        end else begin
                            // Next block is fetched while this one finishes
                            blk_col <= last_col ? '0 : blk_col + 5'd1;
                            blk_row <= last_col ? blk_row + 5'd1 : blk_row;
                            fetch_req <= 1'b1;
                            seq_state <= S_COMMON_CS_FETCH;
                        end
                    end
                end
                S_COMMON_CS_FETCH: begin
                    if (cs_got && !cs_ack && fetch_got && !fetch_ack) begin
                        cs_got <= 1'b0;
                        fetch_got <= 1'b0;
                        ws_req <= 1'b1;
                        ct_req <= 1'b1;
                        seq_state <= S_COMMON_WS_CT;
                    end
                end
                S_LEADOUT_CS: begin
                    if (cs_got && !cs_ack) begin
                        cs_got <= 1'b0;
                        ws_req <= 1'b1;
                        seq_state <= S_LEADOUT_WS;
                    end
                end
                S_LEADOUT_WS: begin
                    if (ws_req && ws_ack) begin
                        done <= 1'b1;
                        seq_state <= S_DONE;
                    end
                end
                S_DONE: begin
                    // Let the writer finish its handshake
                    if (!ws_ack) begin
                        ws_got <= 1'b0;
                        seq_state <= S_IDLE;
                    end
                end
                default: seq_state <= S_IDLE;
            endcase
        end
    end

    always_comb begin
        if (seq_state == S_LEADIN_FETCH || seq_state == S_COMMON_CS_FETCH) begin
            sram_address = fetch_address;
            sram_write_data = '0;
            sram_we_n = fetch_we_n;
        end else if (seq_state == S_COMMON_WS_CT || seq_state == S_LEADOUT_WS) begin
            sram_address = ws_address;
            sram_write_data = ws_write_data;
            sram_we_n = ws_we_n;
        end else begin
            sram_address = '0;
            sram_write_data = '0;
            sram_we_n = 1'b1;
        end
    end

endmodule

//--- design/write_block.sv
`timescale 1ns/1ps

module write_block (
    input logic Clock_50,
    input logic Resetn,
    input logic req,
    output logic ack,
    input idct_pkg::blk_idx_t block_row,
    input idct_pkg::blk_idx_t block_col,
    output idct_pkg::sram_addr_t sram_address,
    output idct_pkg::sram_data_t sram_write_data,
    output logic sram_we_n,
    block_ram_if.reader s_rd
);
    import idct_pkg::*;

    logic reading, vld1;
    buf_addr_t rd_idx, idx1;
    pixel_t even_pixel, odd_pixel;
    sram_addr_t word_row, word_col;

    assign s_rd.address_b = rd_idx;
    assign odd_pixel = s_rd.read_data_b[7:0];

    // Two pixels per word, so the column index drops its low bit
    assign word_row = sram_addr_t'({block_row, idx1[5:3]});
    assign word_col = sram_addr_t'({block_col, idx1[2:1]});

    always_ff @(posedge Clock_50 or negedge Resetn) begin
        if (!Resetn) begin
            reading <= 1'b0;
            rd_idx <= '0;
            vld1 <= 1'b0;
            sram_we_n <= 1'b1;
            ack <= 1'b0;
        end else begin
            vld1 <= reading;
            sram_we_n <= !(vld1 && idx1[0]);
            if (reading) begin
                rd_idx <= rd_idx + 6'd1;
                if (rd_idx == 6'd63) reading <= 1'b0;
            end else if (req && !ack && !vld1) begin
                reading <= 1'b1;
                rd_idx <= '0;
            end
            // Raised with the last word going onto the bus
            if (vld1 && idx1 == 6'd63) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock_50) begin
        idx1 <= rd_idx;
        if (vld1 && !idx1[0]) begin
            even_pixel <= s_rd.read_data_b[7:0];
        end
        sram_address <= sram_addr_t'(PIXEL_BASE + word_row * (IMG_WIDTH / 2) + word_col);
        sram_write_data <= {even_pixel, odd_pixel};
    end

endmodule

//--- design/compute_s.sv
`timescale 1ns/1ps

module compute_s (
    input logic Clock_50,
    input logic Resetn,
    input logic req,
    output logic ack,
    block_ram_if.reader t_rd,
    block_ram_if.writer s_wr
);
    import idct_pkg::*;

    logic running;
    logic [8:0] cnt;
    logic vld1, last1;
    logic [2:0] k1, r1;
    buf_addr_t out_addr1;
    acc_t acc, product, sum, scaled;
    pixel_t pixel;

    // cnt is {col, row, k}, T walked down the column
    assign t_rd.address_b = {cnt[2:0], cnt[8:6]};

    assign product = t_rd.read_data_b * acc_t'(IDCT_COEF[k1][r1]);
    assign sum = (k1 == 3'd0) ? product : acc + product;
    assign scaled = sum >>> S_SHIFT;

    // Clip to pixel range
    always_comb begin
        if (scaled < 0) begin
            pixel = '0;
        end else if (scaled > 255) begin
            pixel = 8'd255;
        end else begin
            pixel = scaled[7:0];
        end
    end

    assign s_wr.address_a = out_addr1;
    assign s_wr.write_data_a = acc_t'(pixel);
    assign s_wr.write_en_a = vld1 && (k1 == 3'd7);

    always_ff @(posedge Clock_50 or negedge Resetn) begin
        if (!Resetn) begin
            running <= 1'b0;
            cnt <= '0;
            vld1 <= 1'b0;
            last1 <= 1'b0;
            ack <= 1'b0;
        end else begin
            vld1 <= running;
            last1 <= running && (cnt == 9'd511);
            if (running) begin
                cnt <= cnt + 9'd1;
                if (cnt == 9'd511) running <= 1'b0;
            end else if (req && !ack && !vld1) begin
                running <= 1'b1;
                cnt <= '0;
            end
            if (last1) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock_50) begin
        k1 <= cnt[2:0];
        r1 <= cnt[5:3];
        out_addr1 <= {cnt[5:3], cnt[8:6]};
        acc <= sum;
    end

endmodule

//--- design/compute_t.sv
`timescale 1ns/1ps

module compute_t (
    input logic Clock_50,
    input logic Resetn,
    input logic req,
    output logic ack,
    block_ram_if.reader sp_rd,
    block_ram_if.writer t_wr
);
    import idct_pkg::*;

    logic running;
    logic [8:0] cnt;
    logic vld1, last1;
    logic [2:0] k1, c1;
    buf_addr_t out_addr1;
    acc_t acc, product, sum;

    // cnt is {row, col, k}, S' walked along the row
    assign sp_rd.address_b = {cnt[8:6], cnt[2:0]};

    assign product = sp_rd.read_data_b * acc_t'(IDCT_COEF[k1][c1]);
    assign sum = (k1 == 3'd0) ? product : acc + product;

    assign t_wr.address_a = out_addr1;
    assign t_wr.write_data_a = sum >>> T_SHIFT;
    assign t_wr.write_en_a = vld1 && (k1 == 3'd7);

    always_ff @(posedge Clock_50 or negedge Resetn) begin
        if (!Resetn) begin
            running <= 1'b0;
            cnt <= '0;
            vld1 <= 1'b0;
            last1 <= 1'b0;
            ack <= 1'b0;
        end else begin
            vld1 <= running;
            last1 <= running && (cnt == 9'd511);
            if (running) begin
                cnt <= cnt + 9'd1;
                if (cnt == 9'd511) running <= 1'b0;
            end else if (req && !ack && !vld1) begin
                running <= 1'b1;
                cnt <= '0;
            end
            if (last1) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    // Second stage lines up with the registered S' read
    always_ff @(posedge Clock_50) begin
        k1 <= cnt[2:0];
        c1 <= cnt[5:3];
        out_addr1 <= cnt[8:3];
        acc <= sum;
    end

endmodule

//--- design/fetch_block.sv
`timescale 1ns/1ps

module fetch_block (
    input logic Clock_50,
    input logic Resetn,
    input logic req,
    output logic ack,
    input idct_pkg::blk_idx_t block_row,
    input idct_pkg::blk_idx_t block_col,
    output idct_pkg::sram_addr_t sram_address,
    output logic sram_we_n,
    input idct_pkg::sram_data_t sram_read_data,
    block_ram_if.writer buf_wr
);
    import idct_pkg::*;

    logic issuing;
    buf_addr_t rd_idx;
    logic [SRAM_READ_LATENCY-1:0] vld_pipe;
    buf_addr_t idx_pipe [SRAM_READ_LATENCY];
    sram_addr_t pix_row, pix_col;
    coef_t coef_in;

    // Pixel position of the coefficient being requested
    assign pix_row = sram_addr_t'({block_row, rd_idx[5:3]});
    assign pix_col = sram_addr_t'({block_col, rd_idx[2:0]});
    assign sram_address = sram_addr_t'(PRE_IDCT_BASE + pix_row * IMG_WIDTH + pix_col);
    assign sram_we_n = 1'b1;

    assign coef_in = coef_t'(sram_read_data);
    assign buf_wr.address_a = idx_pipe[SRAM_READ_LATENCY-1];
    assign buf_wr.write_data_a = acc_t'(coef_in);
    assign buf_wr.write_en_a = vld_pipe[SRAM_READ_LATENCY-1];

    always_ff @(posedge Clock_50 or negedge Resetn) begin
        if (!Resetn) begin
            issuing <= 1'b0;
            rd_idx <= '0;
            vld_pipe <= '0;
            ack <= 1'b0;
        end else begin
            vld_pipe[0] <= issuing;
            for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
            end
            if (issuing) begin
                rd_idx <= rd_idx + 6'd1;
                if (rd_idx == 6'd63) issuing <= 1'b0;
            end else if (req && !ack && !(|vld_pipe)) begin
                issuing <= 1'b1;
                rd_idx <= '0;
            end
            // Last word lands in the buffer
            if (vld_pipe[SRAM_READ_LATENCY-1] && idx_pipe[SRAM_READ_LATENCY-1] == 6'd63) begin
                ack <= 1'b1;
            end else if (ack && !req) begin
                ack <= 1'b0;
            end
        end
    end

    always_ff @(posedge Clock_50) begin
        idx_pipe[0] <= rd_idx;
        for (int i = 1; i < SRAM_READ_LATENCY; i++) begin
            idx_pipe[i] <= idx_pipe[i-1];
        end
    end

endmodule

//--- design/block_dpram.sv
`timescale 1ns/1ps

module block_dpram (
    input logic Clock_50,
    block_ram_if.mem ram
);
    import idct_pkg::*;

    acc_t storage [64];

    always_ff @(posedge Clock_50) begin
        if (ram.write_en_a) begin
            storage[ram.address_a] <= ram.write_data_a;
        end
        // Data valid the cycle after the address
        ram.read_data_b <= storage[ram.address_b];
    end

endmodule

//--- design/block_ram_if.sv
`timescale 1ns/1ps

interface block_ram_if;
    import idct_pkg::*;

    // Port a writes, port b reads
    buf_addr_t address_a;
    acc_t write_data_a;
    logic write_en_a;
    buf_addr_t address_b;
    acc_t read_data_b;

    modport writer (output address_a, output write_data_a, output write_en_a);
    modport reader (output address_b, input read_data_b);
    modport mem (
        input address_a,
        input write_data_a,
        input write_en_a,
        input address_b,
        output read_data_b
    );

endinterface

//--- design/idct_pkg.sv
package idct_pkg;

    typedef logic signed [15:0] coef_t;
    typedef logic signed [31:0] acc_t;
    typedef logic [7:0] pixel_t;
    typedef logic [17:0] sram_addr_t;
    typedef logic [15:0] sram_data_t;
    typedef logic [5:0] buf_addr_t;
    typedef logic [4:0] blk_idx_t;

    // Image grid in 8x8 blocks
    localparam int BLOCK_ROWS = 2;
    localparam int BLOCK_COLS = 3;
    localparam int IMG_WIDTH = BLOCK_COLS * 8;

    // Memory map
    localparam sram_addr_t PRE_IDCT_BASE = 18'd0;
    localparam sram_addr_t PIXEL_BASE = 18'd4096;
    localparam int SRAM_READ_LATENCY = 2;

    localparam int T_SHIFT = 8;
    localparam int S_SHIFT = 16;

    // Cosine basis scaled by 4096, [frequency][sample]
    localparam int IDCT_COEF [8][8] = '{
        '{1448,  1448,  1448,  1448,  1448,  1448,  1448,  1448},
        '{2008,  1702,  1137,   399,  -399, -1137, -1702, -2008},
        '{1892,   783,  -783, -1892, -1892,  -783,   783,  1892},
        '{1702,  -399, -2008, -1137,  1137,  2008,   399, -1702},
        '{1448, -1448, -1448,  1448,  1448, -1448, -1448,  1448},
        '{1137, -2008,   399,  1702, -1702,  -399,  2008, -1137},
        '{ 783, -1892,  1892,  -783,  -783,  1892, -1892,   783},
        '{ 399, -1137,  1702, -2008,  2008, -1702,  1137,  -399}
    };

    typedef enum logic [2:0] {
        S_IDLE,
        S_LEADIN_FETCH,
        S_LEADIN_CT,
        S_COMMON_CS_FETCH,
        S_COMMON_WS_CT,
        S_LEADOUT_CS,
        S_LEADOUT_WS,
        S_DONE
    } seq_state_t;

endpackage
